/* Makefile */
# Verilator simulation of the token engine testbench
# a failing run ends in $fatal, so the sim target exits non-zero

VERILATOR ?= verilator
TOP       ?= tb_token_engine
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* src.f */
verilog/token_engine_pkg.sv
verilog/pass_sequencer.sv
verilog/glb_addr_gen.sv
verilog/token_stage.sv
verilog/psum_writeback.sv
verilog/token_engine_top.sv
verification/token_engine_assertions.sv
verification/tb_token_engine.sv

/* verification/tb_token_engine.sv */
module tb_token_engine;
    import token_engine_pkg::*;

    localparam int NUM_PASSES = 3;

    // expected read address and target stream
    typedef struct packed {
        glb_addr_t addr;
        stream_t   stream;
    } read_exp_t;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      pass_start = 1'b0;
    pass_cfg_t pass_cfg = '0;
    logic      pass_done;
    glb_addr_t glb_read_addr;
    logic      glb_read_ready;
    logic      glb_read_valid = 1'b0;
    word_t     glb_read_data = '0;
    word_t     token_data;
    logic      pe_weight_valid;
    logic      pe_weight_ready = 1'b0;
    logic      pe_ifmap_valid;
    logic      pe_ifmap_ready = 1'b0;
    logic      pe_bias_valid;
    logic      pe_bias_ready = 1'b0;
    word_t     pe_psum_data = '0;
    logic      pe_psum_valid = 1'b0;
    logic      pe_psum_ready;
    glb_addr_t glb_write_addr;
    word_t     glb_write_data;
    logic      glb_write_ready;
    logic      glb_write_valid = 1'b0;

    integer     seed = 32'h964e;
    logic [1:0] read_delay = 2'd0;     // glb latency left
    word_t      psum_q[$];             // popped, not yet written
    int         rd_cnt = 0;
    int         tok_cnt = 0;
    int         wr_cnt = 0;
    bit         pass_active = 1'b0;
    int         done_count = 0;

    token_engine_top DUT (.*);

    always #5 clk = ~clk;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic word_t glb_word(input glb_addr_t addr);
        return {addr ^ 16'ha5c3, addr * 16'd40503 + 16'd1};   // every address bit matters
    endfunction

    function automatic int tile_of(input pass_cfg_t cfg);
        return (cfg.layer == LAYER_DEPTHWISE) ? TILE_DW : TILE_FULL;
    endfunction

    function automatic int reads_in_pass(input pass_cfg_t cfg);
        return tile_of(cfg) + int'(cfg.rounds) * 2 * tile_of(cfg);
    endfunction

    function automatic int pass_len(input pass_cfg_t cfg);
        return reads_in_pass(cfg) + int'(cfg.rounds) * tile_of(cfg);   // reads plus writes
    endfunction

    // nth read of a pass walks the weight tile then ifmap and bias tiles per round
    function automatic read_exp_t ref_read(input pass_cfg_t cfg, input int n);
        read_exp_t r;
        int        tile;
        int        m;
        int        round_idx;
        int        k;
        tile = tile_of(cfg);
        if (n < tile) begin
            r.stream = STREAM_WEIGHT;
            r.addr   = cfg.base_weight + glb_addr_t'(PACK_BYTES * n);
        end else begin
            m         = n - tile;
            round_idx = m / (2 * tile);
            k         = m % (2 * tile);
            if (k < tile) begin
                r.stream = STREAM_IFMAP;   // ifmap keeps walking across rounds
                r.addr   = cfg.base_ifmap + glb_addr_t'(PACK_BYTES * (round_idx * tile + k));
            end else begin
                r.stream = STREAM_BIAS;    // bias rewinds each round
                r.addr   = cfg.base_bias + glb_addr_t'(PACK_BYTES * (k - tile));
            end
        end
        return r;
    endfunction

    function automatic pass_cfg_t make_cfg(input int idx);
        pass_cfg_t c;
        case (idx)
            0:       c = '{LAYER_CONV, 8'd2, 16'h0100, 16'h1000, 16'h2000, 16'h3000};
            1:       c = '{LAYER_DEPTHWISE, 8'd3, 16'h4400, 16'h5000, 16'h6000, 16'h7000};
            default: c = '{LAYER_POINTWISE, 8'd1, 16'hffc0, 16'h9000, 16'ha000, 16'hfff8};
        endcase
        return c;
    endfunction

    // stream the pe side is presenting
    function automatic stream_t valid_stream();
        if (pe_ifmap_valid) return STREAM_IFMAP;
        if (pe_bias_valid) return STREAM_BIAS;
        return STREAM_WEIGHT;
    endfunction

    // ------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------
    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        abort_run();
    endtask

    task automatic check_addr(input string name, input glb_addr_t got, input glb_addr_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: expected %h, got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: expected %h, got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_stream(input string name, input stream_t got, input stream_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: expected %s, got %s", $time, name, exp.name(), got.name());
            abort_run();
        end
    endtask

    // ------------------------------------------------------------
    // glb, pe and psum models
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            glb_read_valid  <= 1'b0;
            pe_weight_ready <= 1'b0;
            pe_ifmap_ready  <= 1'b0;
            pe_bias_ready   <= 1'b0;
            pe_psum_valid   <= 1'b0;
            glb_write_valid <= 1'b0;
        end else begin
            if (glb_read_valid && glb_read_ready) begin
                glb_read_valid <= 1'b0;                    // one cycle of valid only
                read_delay     <= 2'($random(seed));       // 0 to 3 cycles next time
            end else if (glb_read_ready && !glb_read_valid) begin
                if (read_delay == 2'd0) begin
                    glb_read_valid <= 1'b1;
                    glb_read_data  <= glb_word(glb_read_addr);
                end else begin
                    read_delay <= read_delay - 2'd1;
                end
            end
            pe_weight_ready <= ($random(seed) & 3) != 0;   // ready about 3 in 4
            pe_ifmap_ready  <= ($random(seed) & 3) != 0;
            pe_bias_ready   <= ($random(seed) & 3) != 0;
            if (pe_psum_valid && pe_psum_ready) begin
                pe_psum_valid <= ($random(seed) & 1) != 0;
                pe_psum_data  <= $random(seed);            // fresh word after each pop
            end else if (!pe_psum_valid) begin
                pe_psum_valid <= ($random(seed) & 3) != 0;
            end
            glb_write_valid <= ($random(seed) & 3) != 0;
        end
    end

    // ------------------------------------------------------------
    // checker
    // ------------------------------------------------------------
    always @(posedge clk) begin
        read_exp_t exp_rd;
        read_exp_t exp_tok;
        if (!rst) begin
            if (pass_start) begin
                rd_cnt      = 0;
                tok_cnt     = 0;
                wr_cnt      = 0;
                pass_active = 1'b1;
            end
            if ((pe_weight_valid && pe_weight_ready) || (pe_ifmap_valid && pe_ifmap_ready)
                    || (pe_bias_valid && pe_bias_ready)) begin
                if (tok_cnt >= rd_cnt)
                    report_error("PE transfer with no pack read from the GLB");
                exp_tok = ref_read(pass_cfg, tok_cnt);
                check_stream("pe valid stream", valid_stream(), exp_tok.stream);
                check_word("token_data", token_data, glb_word(exp_tok.addr));
                tok_cnt++;
            end
            if (glb_read_ready && glb_read_valid) begin
                if (!pass_active || rd_cnt >= reads_in_pass(pass_cfg))
                    report_error("GLB read beyond the end of the pass");
                exp_rd = ref_read(pass_cfg, rd_cnt);
                check_addr("glb_read_addr", glb_read_addr, exp_rd.addr);
                rd_cnt++;
            end
            if (pe_psum_ready && pe_psum_valid)
                psum_q.push_back(pe_psum_data);
            if (glb_write_ready && glb_write_valid) begin
                if (psum_q.size() == 0)
                    report_error("GLB write with no psum popped");
                check_addr("glb_write_addr", glb_write_addr,
                           pass_cfg.base_opsum + glb_addr_t'(PACK_BYTES * wr_cnt));
                check_word("glb_write_data", glb_write_data, psum_q.pop_front());
                wr_cnt++;
            end
            if (pass_done) begin
                if (!pass_active)
                    report_error("pass_done pulsed with no pass running");
                if (rd_cnt != reads_in_pass(pass_cfg) || tok_cnt != rd_cnt)
                    report_error($sformatf("pass ended after %0d reads and %0d tokens",
                                           rd_cnt, tok_cnt));
                if (wr_cnt != int'(pass_cfg.rounds) * tile_of(pass_cfg) || psum_q.size() != 0)
                    report_error($sformatf("pass ended after %0d writes", wr_cnt));
                pass_active = 1'b0;
                done_count <= done_count + 1;
            end
        end
    end

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int p = 0; p < NUM_PASSES; p++) begin
            pass_cfg   <= make_cfg(p);
            pass_start <= 1'b1;
            @(posedge clk);
            pass_start <= 1'b0;
            @(posedge clk);
            if (!glb_read_ready)
                report_error("glb_read_ready not high on the cycle after pass_start");
            while (done_count == p) @(posedge clk);
            repeat (6) @(posedge clk);   // idle gap where a second pass_done would show
        end
        $display("Everything OK");
        $finish;
    end

    // watchdog allows 8 cycles per read or write plus reset and gaps
    initial begin
        int budget;
        budget = 64;
        for (int p = 0; p < NUM_PASSES; p++) begin
            budget += pass_len(make_cfg(p)) * 8;
        end
        repeat (budget) @(posedge clk);
        report_error($sformatf("timeout, run still busy after %0d cycles", budget));
    end

endmodule

/* verification/token_engine_assertions.sv */
module token_engine_assertions (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pass_done,
    input  logic                          glb_read_ready,
    input  logic                          glb_read_valid,
    input  token_engine_pkg::glb_addr_t   glb_read_addr,
    input  logic                          pe_weight_valid,
    input  logic                          pe_ifmap_valid,
    input  logic                          pe_bias_valid,
    input  logic                          pe_psum_ready,
    input  logic                          glb_write_ready
);
    import token_engine_pkg::*;

    // ------------------------------------------------------------
    // protocol rules
    // ------------------------------------------------------------
    a_one_pe_valid: assert property (@(posedge clk) disable iff (rst)
        $onehot0({pe_weight_valid, pe_ifmap_valid, pe_bias_valid}))
        else $error("more than one PE valid high");

    // one pack in flight, no read while a pack waits
    a_read_vs_token: assert property (@(posedge clk) disable iff (rst)
        !(glb_read_ready && (pe_weight_valid || pe_ifmap_valid || pe_bias_valid)))
        else $error("glb_read_ready high while a PE valid is high");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        pass_done |=> !pass_done)
        else $error("pass_done longer than one cycle");

    a_pop_vs_write: assert property (@(posedge clk) disable iff (rst)
        !(glb_write_ready && pe_psum_ready))
        else $error("glb_write_ready and pe_psum_ready high together");

    // request held with a steady address until the glb answers
    a_read_held: assert property (@(posedge clk) disable iff (rst)
        glb_read_ready && !glb_read_valid |=> glb_read_ready && $stable(glb_read_addr))
        else $error("GLB read request dropped or moved before valid");

endmodule

bind token_engine_top token_engine_assertions u_assertions (
    .clk             (clk),
    .rst             (rst),
    .pass_done       (pass_done),
    .glb_read_ready  (glb_read_ready),
    .glb_read_valid  (glb_read_valid),
    .glb_read_addr   (glb_read_addr),
    .pe_weight_valid (pe_weight_valid),
    .pe_ifmap_valid  (pe_ifmap_valid),
    .pe_bias_valid   (pe_bias_valid),
    .pe_psum_ready   (pe_psum_ready),
    .glb_write_ready (glb_write_ready)
);

/* verilog/glb_addr_gen.sv */
module glb_addr_gen (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pass_start,
    input  logic                          fetch_accept,
    input  logic                          round_start,
    input  logic                          psum_written,
    input  token_engine_pkg::pass_cfg_t   pass_cfg,
    input  token_engine_pkg::stream_t     fetch_stream,
    output token_engine_pkg::glb_addr_t   glb_read_addr,
    output token_engine_pkg::glb_addr_t   glb_write_addr
);
    import token_engine_pkg::*;

    localparam glb_addr_t PACK_STEP = glb_addr_t'(PACK_BYTES);

    glb_addr_t weight_ptr;
    glb_addr_t ifmap_ptr;     // runs across the whole pass
    glb_addr_t bias_ptr;      // rewinds each round
    glb_addr_t opsum_ptr;
    logic      step_weight;
    logic      step_ifmap;
    logic      step_bias;

    // only the stream being fetched moves
    assign step_weight = fetch_accept && (fetch_stream == STREAM_WEIGHT);
    assign step_ifmap  = fetch_accept && (fetch_stream == STREAM_IFMAP);
    assign step_bias   = fetch_accept && (fetch_stream == STREAM_BIAS);

    // ------------------------------------------------------------
    // pointers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            weight_ptr <= '0;
            ifmap_ptr  <= '0;
            bias_ptr   <= '0;
            opsum_ptr  <= '0;
        end else if (pass_start) begin
            weight_ptr <= pass_cfg.base_weight;
            ifmap_ptr  <= pass_cfg.base_ifmap;
            bias_ptr   <= pass_cfg.base_bias;
            opsum_ptr  <= pass_cfg.base_opsum;
        end else begin
            if (step_weight) begin
                weight_ptr <= weight_ptr + PACK_STEP;
            end
            if (step_ifmap) begin
                ifmap_ptr <= ifmap_ptr + PACK_STEP;
            end
            if (round_start) begin
                bias_ptr <= pass_cfg.base_bias;      // same bias tile every round
            end else if (step_bias) begin
                bias_ptr <= bias_ptr + PACK_STEP;
            end
            if (psum_written) begin
                opsum_ptr <= opsum_ptr + PACK_STEP;  // one word per channel write
            end
        end
    end

    // ------------------------------------------------------------
    // read address follows the current stream
    // ------------------------------------------------------------
    always_comb begin
        case (fetch_stream)
            STREAM_IFMAP: glb_read_addr = ifmap_ptr;
            STREAM_BIAS:  glb_read_addr = bias_ptr;
            default:      glb_read_addr = weight_ptr;
        endcase
    end

    assign glb_write_addr = opsum_ptr;   // stable until write accepted

endmodule

/* verilog/pass_sequencer.sv */
module pass_sequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pass_start,
    input  token_engine_pkg::pass_cfg_t  pass_cfg,
    input  logic                         glb_read_valid,
    input  logic                         token_taken,
    input  logic                         psum_written,
    output logic                         glb_read_ready,
    output logic                         fetch_accept,
    output logic                         round_start,
    output logic                         pop_start,
    output logic                         pass_done,
    output token_engine_pkg::stream_t    fetch_stream
);
    import token_engine_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WEIGHT,    // weight read and forward
        S_IFMAP,     // ifmap read and forward
        S_BIAS,      // bias read and forward
        S_DRAIN,     // psum pop and writeback
        S_DONE
    } state_t;

    state_t                 state;
    state_t                 state_nxt;
    layer_t                 layer_q;
    logic [CNT_WIDTH-1:0]   tile_d;
    logic [CNT_WIDTH-1:0]   tile_k;
    logic [CNT_WIDTH-1:0]   phase_limit;
    logic [CNT_WIDTH-1:0]   pack_cnt;     // packs forwarded in this phase
    logic [CNT_WIDTH-1:0]   psum_cnt;     // writes done in this round
    logic [ROUND_WIDTH-1:0] round_cnt;
    logic                   wait_token;   // pack sits in token stage
    logic                   in_fetch;
    logic                   phase_end;
    logic                   last_psum;
    logic                   last_round;
    logic                   drain_end;

    // ------------------------------------------------------------
    // tile size from the latched layer
    // ------------------------------------------------------------
    always_comb begin
        if (layer_q == LAYER_DEPTHWISE) begin
            tile_d = CNT_WIDTH'(TILE_DW);
            tile_k = CNT_WIDTH'(TILE_DW);
        end else begin
            tile_d = CNT_WIDTH'(TILE_FULL);   // conv and pointwise
            tile_k = CNT_WIDTH'(TILE_FULL);
        end
    end

    assign phase_limit = (state == S_BIAS) ? tile_k : tile_d;   // one bias word per channel
    assign phase_end   = token_taken && (pack_cnt == phase_limit - 1'b1);
    assign last_psum   = (psum_cnt == tile_k - 1'b1);
    assign last_round  = (round_cnt + 1'b1) >= pass_cfg.rounds;  // zero rounds runs one
    assign drain_end   = (state == S_DRAIN) && psum_written && last_psum;

    // ------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:   if (pass_start) state_nxt = S_WEIGHT;
            S_WEIGHT: if (phase_end) state_nxt = S_IFMAP;
            S_IFMAP:  if (phase_end) state_nxt = S_BIAS;
            S_BIAS:   if (phase_end) state_nxt = S_DRAIN;
            S_DRAIN:  if (drain_end) state_nxt = last_round ? S_DONE : S_IFMAP;
            S_DONE:   state_nxt = S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            layer_q    <= LAYER_CONV;
            wait_token <= 1'b0;
            pack_cnt   <= '0;
            psum_cnt   <= '0;
            round_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (state == S_IDLE && pass_start) begin
                layer_q   <= pass_cfg.layer;     // tile size fixed for the pass
                round_cnt <= '0;
            end
            // one read outstanding, next one waits for the pe transfer
            if (fetch_accept) begin
                wait_token <= 1'b1;
            end else if (token_taken) begin
                wait_token <= 1'b0;
            end
            if (token_taken) begin
                pack_cnt <= phase_end ? '0 : pack_cnt + 1'b1;
            end
            if (psum_written) begin
                psum_cnt <= last_psum ? '0 : psum_cnt + 1'b1;
            end
            if (drain_end && !last_round) begin
                round_cnt <= round_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // strobes and levels
    // ------------------------------------------------------------
    assign in_fetch       = (state == S_WEIGHT) || (state == S_IFMAP) || (state == S_BIAS);
    assign glb_read_ready = in_fetch && !wait_token;
    assign fetch_accept   = glb_read_ready && glb_read_valid;

    // entering ifmap marks a new round
    assign round_start = ((state == S_WEIGHT) && phase_end) || (drain_end && !last_round);

    // first pop after bias tile, then one per finished write
    assign pop_start = ((state == S_BIAS) && phase_end)
                     || ((state == S_DRAIN) && psum_written && !last_psum);

    assign pass_done = (state == S_DONE);

    always_comb begin
        case (state)
            S_IFMAP: fetch_stream = STREAM_IFMAP;
            S_BIAS:  fetch_stream = STREAM_BIAS;
            default: fetch_stream = STREAM_WEIGHT;
        endcase
    end

endmodule

/* verilog/psum_writeback.sv */
module psum_writeback (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pop_start,
    input  logic                     pe_psum_valid,
    input  logic                     glb_write_valid,
    input  token_engine_pkg::word_t  pe_psum_data,
    output logic                     pe_psum_ready,
    output logic                     glb_write_ready,
    output logic                     psum_written,
    output token_engine_pkg::word_t  glb_write_data
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_POP,      // waiting on the psum buffer
        P_WRITE     // waiting on the glb
    } wb_state_t;

    wb_state_t state;
    logic      pop_fire;

    assign pop_fire = pe_psum_ready && pe_psum_valid;

    // ------------------------------------------------------------
    // pop then write one word at a time
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= P_IDLE;
        end else begin
            case (state)
                P_IDLE:  if (pop_start) state <= P_POP;
                P_POP:   if (pop_fire) state <= P_WRITE;
                // next pop may be asked for on the write accept cycle
                P_WRITE: if (psum_written) state <= pop_start ? P_POP : P_IDLE;
                default: state <= P_IDLE;
            endcase
        end
    end

    // word held for the whole write request
    always_ff @(posedge clk) begin
        if (pop_fire) begin
            glb_write_data <= pe_psum_data;
        end
    end

    assign pe_psum_ready   = (state == P_POP);
    assign glb_write_ready = (state == P_WRITE);
    assign psum_written    = glb_write_ready && glb_write_valid;

endmodule

/* verilog/token_engine_pkg.sv */
package token_engine_pkg;

    // ------------------------------------------------------------
    // widths and steps
    // ------------------------------------------------------------
    localparam int ADDR_WIDTH  = 16;   // glb byte address
    localparam int DATA_WIDTH  = 32;   // one 4-byte pack
    localparam int PACK_BYTES  = 4;    // pointer step per pack
    localparam int CNT_WIDTH   = 6;    // holds up to tile 32
    localparam int ROUND_WIDTH = 8;

    // tile sizes per layer kind
    localparam int TILE_FULL = 32;     // conv and pointwise
    localparam int TILE_DW   = 10;     // depthwise

    typedef logic [ADDR_WIDTH-1:0] glb_addr_t;
    typedef logic [DATA_WIDTH-1:0] word_t;

    typedef enum logic [1:0] {
        LAYER_CONV      = 2'd0,
        LAYER_POINTWISE = 2'd1,
        LAYER_DEPTHWISE = 2'd2
    } layer_t;

    // which pe input a fetched pack belongs to
    typedef enum logic [1:0] {
        STREAM_WEIGHT = 2'd0,
        STREAM_IFMAP  = 2'd1,
        STREAM_BIAS   = 2'd2
    } stream_t;

    // ------------------------------------------------------------
    // per pass configuration, held stable for the whole pass
    // ------------------------------------------------------------
    typedef struct packed {
        layer_t                 layer;        // picks tile size
        logic [ROUND_WIDTH-1:0] rounds;       // ifmap/bias/psum rounds
        glb_addr_t              base_weight;
        glb_addr_t              base_ifmap;
        glb_addr_t              base_bias;    // reused every round
        glb_addr_t              base_opsum;
    } pass_cfg_t;

endpackage

/* verilog/token_engine_top.sv */
module token_engine_top (
    input  logic                          clk,
    input  logic                          rst,
    // pass control
    input  logic                          pass_start,
    input  token_engine_pkg::pass_cfg_t   pass_cfg,
    output logic                          pass_done,
    // glb read
    output token_engine_pkg::glb_addr_t   glb_read_addr,
    output logic                          glb_read_ready,
    input  logic                          glb_read_valid,
    input  token_engine_pkg::word_t       glb_read_data,
    // pe array
    output token_engine_pkg::word_t       token_data,
    output logic                          pe_weight_valid,
    input  logic                          pe_weight_ready,
    output logic                          pe_ifmap_valid,
    input  logic                          pe_ifmap_ready,
    output logic                          pe_bias_valid,
    input  logic                          pe_bias_ready,
    // psum pop
    input  token_engine_pkg::word_t       pe_psum_data,
    input  logic                          pe_psum_valid,
    output logic                          pe_psum_ready,
    // glb write
    output token_engine_pkg::glb_addr_t   glb_write_addr,
    output token_engine_pkg::word_t       glb_write_data,
    output logic                          glb_write_ready,
    input  logic                          glb_write_valid
);
    import token_engine_pkg::*;

    stream_t fetch_stream;
    logic    fetch_accept;
    logic    round_start;
    logic    pop_start;
    logic    token_taken;
    logic    psum_written;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    pass_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .pass_start     (pass_start),
        .pass_cfg       (pass_cfg),
        .glb_read_valid (glb_read_valid),
        .token_taken    (token_taken),
        .psum_written   (psum_written),
        .glb_read_ready (glb_read_ready),
        .fetch_accept   (fetch_accept),
        .round_start    (round_start),
        .pop_start      (pop_start),
        .pass_done      (pass_done),
        .fetch_stream   (fetch_stream)
    );

    glb_addr_gen u_addr (
        .clk            (clk),
        .rst            (rst),
        .pass_start     (pass_start),
        .fetch_accept   (fetch_accept),
        .round_start    (round_start),
        .psum_written   (psum_written),
        .pass_cfg       (pass_cfg),
        .fetch_stream   (fetch_stream),
        .glb_read_addr  (glb_read_addr),
        .glb_write_addr (glb_write_addr)
    );

    // ------------------------------------------------------------
    // data paths
    // ------------------------------------------------------------
    token_stage u_token (
        .clk             (clk),
        .rst             (rst),
        .fetch_accept    (fetch_accept),
        .fetch_stream    (fetch_stream),
        .glb_read_data   (glb_read_data),
        .pe_weight_ready (pe_weight_ready),
        .pe_ifmap_ready  (pe_ifmap_ready),
        .pe_bias_ready   (pe_bias_ready),
        .token_data      (token_data),
        .pe_weight_valid (pe_weight_valid),
        .pe_ifmap_valid  (pe_ifmap_valid),
        .pe_bias_valid   (pe_bias_valid),
        .token_taken     (token_taken)
    );

    psum_writeback u_psum (
        .clk             (clk),
        .rst             (rst),
        .pop_start       (pop_start),
        .pe_psum_valid   (pe_psum_valid),
        .glb_write_valid (glb_write_valid),
        .pe_psum_data    (pe_psum_data),
        .pe_psum_ready   (pe_psum_ready),
        .glb_write_ready (glb_write_ready),
        .psum_written    (psum_written),
        .glb_write_data  (glb_write_data)
    );

endmodule

/* verilog/token_stage.sv */
module token_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetch_accept,
    input  token_engine_pkg::stream_t  fetch_stream,
    input  token_engine_pkg::word_t    glb_read_data,
    input  logic                       pe_weight_ready,
    input  logic                       pe_ifmap_ready,
    input  logic                       pe_bias_ready,
    output token_engine_pkg::word_t    token_data,
    output logic                       pe_weight_valid,
    output logic                       pe_ifmap_valid,
    output logic                       pe_bias_valid,
    output logic                       token_taken
);
    import token_engine_pkg::*;

    logic    held;        // a pack waits for the pe array
    stream_t stream_q;    // stream of the held pack
    word_t   data_q;
    logic    ready_sel;

    // ------------------------------------------------------------
    // capture, glb data is only valid for the accept cycle
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (fetch_accept) begin
            data_q   <= glb_read_data;
            stream_q <= fetch_stream;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (fetch_accept) begin
            held <= 1'b1;
        end else if (token_taken) begin
            held <= 1'b0;   // drop after the pe transfer
        end
    end

    // ready of the pe input the pack is aimed at
    always_comb begin
        case (stream_q)
            STREAM_IFMAP: ready_sel = pe_ifmap_ready;
            STREAM_BIAS:  ready_sel = pe_bias_ready;
            default:      ready_sel = pe_weight_ready;
        endcase
    end

    assign pe_weight_valid = held && (stream_q == STREAM_WEIGHT);
    assign pe_ifmap_valid  = held && (stream_q == STREAM_IFMAP);
    assign pe_bias_valid   = held && (stream_q == STREAM_BIAS);

    assign token_taken = held && ready_sel;   // same cycle as the transfer
    assign token_data  = data_q;              // shared by all three streams

endmodule
